// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       := gb_cart_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
hw/gb_bus_pkg.sv
hw/gb_cart_pkg.sv
hw/cart_header_capture.sv
hw/mbc_regs.sv
hw/mbc_mapper.sv
hw/cart_ram.sv
hw/gb_cart_top.sv
verif/gb_cart_asserts.sv
verif/gb_cart_tb.sv

// File: hw/cart_header_capture.sv
// --------------------
// snoops the ROM download for the cartridge header
// keeps type, rom size and ram size bytes and decodes the controller
// kind plus the bank masks used for mirroring
// --------------------
`default_nettype none

module cart_header_capture
	import gb_bus_pkg::*, gb_cart_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      dl_active,
	input  logic      dl_wr,
	input  dl_addr_t  dl_addr,
	input  dl_data_t  dl_data,
	output mbc_kind_e mbc_kind,
	output rom_bank_t rom_mask,
	output ram_bank_t ram_mask
);

	logic [7:0] type_byte;
	logic [7:0] rom_size;
	logic [7:0] ram_size;

	// header words are written once per download, 0146 then 0148
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_byte <= 8'h00;
			rom_size  <= 8'h00;
			ram_size  <= 8'h00;
		end else if (dl_active && dl_wr) begin
			if (dl_addr == HDR_TYPE_ADDR)
				type_byte <= dl_data[15:8];
			if (dl_addr == HDR_SIZE_ADDR) begin
				rom_size <= dl_data[7:0];
				ram_size <= dl_data[15:8];
			end
		end
	end

	// cartridge type byte to controller family
	// battery / timer / rumble variants collapse onto the base kind
	always_comb begin
		case (type_byte) inside
			[8'd1:8'd3]:   mbc_kind = mbc_1;
			[8'd5:8'd6]:   mbc_kind = mbc_2;
			[8'd15:8'd19]: mbc_kind = mbc_3;
			[8'd25:8'd30]: mbc_kind = mbc_5;
			default:       mbc_kind = mbc_none;
		endcase
	end

	// rom size code to bank mask
	always_comb begin
		case (rom_size)
			8'd1:    rom_mask = 7'b0000011;
			8'd2:    rom_mask = 7'b0000111;
			8'd3:    rom_mask = 7'b0001111;
			8'd4:    rom_mask = 7'b0011111;
			8'd5:    rom_mask = 7'b0111111;
			8'd6:    rom_mask = 7'b1111111;
			// 72 and 80 bank parts
			8'd82:   rom_mask = 7'b1000111;
			8'd83:   rom_mask = 7'b1001111;
			default: rom_mask = ROM_MASK_DEFAULT;
		endcase
	end

	// 2K and 8K parts have a single bank, everything else gets four
	assign ram_mask = (ram_size == 8'd1 || ram_size == 8'd2) ? 2'b00 : 2'b11;

endmodule

`default_nettype wire

// File: hw/cart_ram.sv
// --------------------
// cartridge RAM, byte wide, single address port
// the raw array word goes out to the mapper, the shaped byte comes
// back and is registered as the console read data
// --------------------
`default_nettype none

module cart_ram
	import gb_bus_pkg::*;
#(
	parameter int CRAM_ADDR_W = 15
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [CRAM_ADDR_W-1:0] addr,
	input  logic                   we,
	input  cart_data_t             wdata,
	input  logic                   re,
	input  cart_data_t             rdata,
	output cart_data_t             mem_q,
	output cart_data_t             q
);

	localparam int DEPTH = 1 << CRAM_ADDR_W;

	cart_data_t mem [DEPTH];

	always_ff @(posedge clk_sys) begin
		if (we)
			mem[addr] <= wdata;
	end

	// array word for the mapper's masking
	assign mem_q = mem[addr];

	// read data register, holds between reads
	always_ff @(posedge clk_sys) begin
		if (reset)
			q <= '0;
		else if (re)
			q <= rdata;
	end

endmodule

`default_nettype wire

// File: hw/gb_bus_pkg.sv
// --------------------
// console bus and ROM download port types
// region decode shared by the bank registers, the mapper and the testbench
// --------------------
`default_nettype none

package gb_bus_pkg;

	// console side
	typedef logic [15:0] cart_addr_t;
	typedef logic [7:0]  cart_data_t;

	// download side, low byte sits at the even address
	typedef logic [24:0] dl_addr_t;
	typedef logic [15:0] dl_data_t;

	// linear ROM byte address, 128 banks of 16K
	typedef logic [21:0] rom_addr_t;
	// cartridge RAM byte address, 4 banks of 8K
	typedef logic [14:0] cram_addr_t;

	// address regions seen by the cartridge, from addr[15:13]
	typedef enum logic [2:0] {
		region_ram_enable,
		region_rom_bank,
		region_ram_bank,
		region_mode,
		region_cram,
		region_other
	} cart_region_e;

	function automatic cart_region_e region_of(input cart_addr_t addr);
		case (addr[15:13])
			3'b000:  return region_ram_enable;
			3'b001:  return region_rom_bank;
			3'b010:  return region_ram_bank;
			3'b011:  return region_mode;
			// A000-BFFF
			3'b101:  return region_cram;
			default: return region_other;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: hw/gb_cart_pkg.sv
// --------------------
// memory bank controller definitions
// controller kinds, bank register types, header offsets and the
// fixed values returned or loaded by the controllers
// --------------------
`default_nettype none

package gb_cart_pkg;

	import gb_bus_pkg::*;

	// controller families handled by the mapper
	typedef enum logic [2:0] {
		mbc_none,
		mbc_1,
		mbc_2,
		mbc_3,
		mbc_5
	} mbc_kind_e;

	// bank register widths
	typedef logic [6:0] rom_bank_t;
	typedef logic [1:0] ram_bank_t;

	// --------------------
	// cartridge header
	// --------------------

	// type byte arrives in the upper byte of this word
	localparam dl_addr_t HDR_TYPE_ADDR = 25'h146;
	// rom size in the lower byte, ram size in the upper byte
	localparam dl_addr_t HDR_SIZE_ADDR = 25'h148;

	// mask for sizes not listed in the table, 96 banks
	localparam rom_bank_t ROM_MASK_DEFAULT = 7'b1011111;

	// --------------------
	// controller constants
	// --------------------

	// low nibble written to 0000-1FFF that opens the RAM
	localparam logic [3:0] RAM_ENABLE_KEY = 4'hA;

	// bank 0 is never selected in the upper ROM window, except on MBC5
	localparam rom_bank_t ROM_BANK_RESET = 7'd1;
	localparam ram_bank_t RAM_BANK_RESET = 2'd0;

	// read values when the RAM is closed or the RTC is mapped in
	localparam cart_data_t CRAM_CLOSED_DATA = 8'hFF;
	localparam cart_data_t CRAM_RTC_DATA    = 8'h00;

	// MBC2 RAM is 512 x 4 bits, upper nibble floats high
	localparam logic [3:0] MBC2_NIBBLE_PAD  = 4'hF;
	localparam logic [6:0] MBC2_RAM_PAGE    = 7'b1010000;

endpackage

`default_nettype wire

// File: hw/gb_cart_top.sv
// --------------------
// cartridge top level
// header capture, bank registers, mapper and cart RAM on clk_sys
// ROM data lives outside, only its byte address leaves here
// --------------------
`default_nettype none

module gb_cart_top
	import gb_bus_pkg::*, gb_cart_pkg::*;
#(
	parameter int CRAM_ADDR_W = 15
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       dl_active,
	input  logic       dl_wr,
	input  dl_addr_t   dl_addr,
	input  dl_data_t   dl_data,
	input  cart_addr_t cart_addr,
	input  logic       cart_rd,
	input  logic       cart_wr,
	input  cart_data_t cart_di,
	output cart_data_t cart_do,
	output rom_addr_t  rom_addr
);

	mbc_kind_e mbc_kind;
	rom_bank_t rom_mask;
	ram_bank_t ram_mask;

	rom_bank_t rom_bank;
	ram_bank_t ram_bank;
	logic      mbc1_mode;
	logic      rtc_mode;
	logic      ram_enable;

	logic [CRAM_ADDR_W-1:0] cram_addr;
	logic                   cram_we;
	logic                   cram_re;
	cart_data_t             cram_q;
	cart_data_t             cram_rdata;

	cart_header_capture hdr0 (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl_active(dl_active),
		.dl_wr    (dl_wr),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.mbc_kind (mbc_kind),
		.rom_mask (rom_mask),
		.ram_mask (ram_mask)
	);

	mbc_regs regs0 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.mbc_kind  (mbc_kind),
		.cart_wr   (cart_wr),
		.cart_addr (cart_addr),
		.cart_di   (cart_di),
		.rom_bank  (rom_bank),
		.ram_bank  (ram_bank),
		.mbc1_mode (mbc1_mode),
		.rtc_mode  (rtc_mode),
		.ram_enable(ram_enable)
	);

	mbc_mapper #(
		.CRAM_ADDR_W(CRAM_ADDR_W)
	) map0 (
		.mbc_kind  (mbc_kind),
		.rom_mask  (rom_mask),
		.ram_mask  (ram_mask),
		.rom_bank  (rom_bank),
		.ram_bank  (ram_bank),
		.mbc1_mode (mbc1_mode),
		.rtc_mode  (rtc_mode),
		.ram_enable(ram_enable),
		.cart_addr (cart_addr),
		.cart_rd   (cart_rd),
		.cart_wr   (cart_wr),
		.cram_q    (cram_q),
		.rom_addr  (rom_addr),
		.cram_addr (cram_addr),
		.cram_we   (cram_we),
		.cram_re   (cram_re),
		.cram_rdata(cram_rdata)
	);

	// shaped byte loops back into the ram's read register
	cart_ram #(
		.CRAM_ADDR_W(CRAM_ADDR_W)
	) cram0 (
		.clk_sys(clk_sys),
		.reset  (reset),
		.addr   (cram_addr),
		.we     (cram_we),
		.wdata  (cart_di),
		.re     (cram_re),
		.rdata  (cram_rdata),
		.mem_q  (cram_q),
		.q      (cart_do)
	);

endmodule

`default_nettype wire

// File: hw/mbc_mapper.sv
// --------------------
// address mapping for the cartridge
// turns console addresses into a linear ROM byte address and a
// cart RAM address, qualifies RAM strobes and shapes read data
// --------------------
`default_nettype none

module mbc_mapper
	import gb_bus_pkg::*, gb_cart_pkg::*;
#(
	parameter int CRAM_ADDR_W = 15
) (
	input  mbc_kind_e              mbc_kind,
	input  rom_bank_t              rom_mask,
	input  ram_bank_t              ram_mask,
	input  rom_bank_t              rom_bank,
	input  ram_bank_t              ram_bank,
	input  logic                   mbc1_mode,
	input  logic                   rtc_mode,
	input  logic                   ram_enable,
	input  cart_addr_t             cart_addr,
	input  logic                   cart_rd,
	input  logic                   cart_wr,
	input  cart_data_t             cram_q,
	output rom_addr_t              rom_addr,
	output logic [CRAM_ADDR_W-1:0] cram_addr,
	output logic                   cram_we,
	output logic                   cram_re,
	output cart_data_t             cram_rdata
);

	rom_bank_t  rom_bank_sel;
	rom_bank_t  rom_bank_eff;
	ram_bank_t  ram_bank_sel;
	ram_bank_t  ram_bank_eff;
	cram_addr_t cram_full;
	logic       in_cram;

	// --------------------
	// rom banking
	// --------------------

	// MBC1 mode 0 puts the ram bank bits on rom lines 20:19
	always_comb begin
		case (mbc_kind)
			mbc_1:   rom_bank_sel = mbc1_mode ? {2'b00, rom_bank[4:0]}
			                                  : {ram_bank, rom_bank[4:0]};
			default: rom_bank_sel = rom_bank;
		endcase
	end

	// mask mirrors the bank into the real rom size
	assign rom_bank_eff = rom_bank_sel & rom_mask;

	always_comb begin
		if (mbc_kind == mbc_none) begin
			// plain 32K cart, no banking at all
			rom_addr = rom_addr_t'(cart_addr[14:0]);
		end else begin
			case (cart_addr[15:14])
				// fixed bank 0
				2'b00:   rom_addr = rom_addr_t'(cart_addr);
				// switchable window
				2'b01:   rom_addr = {1'b0, rom_bank_eff, cart_addr[13:0]};
				default: rom_addr = '0;
			endcase
		end
	end

	// --------------------
	// cart ram banking
	// --------------------
	always_comb begin
		case (mbc_kind)
			// only mode 1 banks the ram on MBC1
			mbc_1:   ram_bank_sel = mbc1_mode ? ram_bank : 2'b00;
			mbc_3:   ram_bank_sel = ram_bank;
			mbc_5:   ram_bank_sel = ram_bank;
			default: ram_bank_sel = 2'b00;
		endcase
	end

	assign ram_bank_eff = ram_bank_sel & ram_mask;
	assign cram_full    = {ram_bank_eff, cart_addr[12:0]};
	// narrower ram drops upper bits and mirrors
	assign cram_addr    = cram_full[CRAM_ADDR_W-1:0];

	// writes go in regardless of the enable, reads are gated below
	assign in_cram = (region_of(cart_addr) == region_cram);
	assign cram_we = cart_wr && in_cram;
	assign cram_re = cart_rd && in_cram;

	// read data shaping, same cycle as the read strobe
	always_comb begin
		if (!ram_enable)
			cram_rdata = CRAM_CLOSED_DATA;
		else if (mbc_kind == mbc_2 && cart_addr[15:9] == MBC2_RAM_PAGE)
			cram_rdata = {MBC2_NIBBLE_PAD, cram_q[3:0]};
		else if (rtc_mode)
			// no clock model, RTC registers read as zero
			cram_rdata = CRAM_RTC_DATA;
		else
			cram_rdata = cram_q;
	end

endmodule

`default_nettype wire

// File: hw/mbc_regs.sv
// --------------------
// bank controller registers written by the console
// rom bank, ram bank, MBC1 mode, MBC3 RTC select and RAM enable
// held at reset values while a ROM is being downloaded
// --------------------
`default_nettype none

module mbc_regs
	import gb_bus_pkg::*, gb_cart_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       dl_active,
	input  mbc_kind_e  mbc_kind,
	input  logic       cart_wr,
	input  cart_addr_t cart_addr,
	input  cart_data_t cart_di,
	output rom_bank_t  rom_bank,
	output ram_bank_t  ram_bank,
	output logic       mbc1_mode,
	output logic       rtc_mode,
	output logic       ram_enable
);

	cart_region_e wr_region;

	// the console sits in reset for the whole download
	logic hold;

	assign wr_region = region_of(cart_addr);
	assign hold      = reset || dl_active;

	always_ff @(posedge clk_sys) begin
		if (hold) begin
			rom_bank   <= ROM_BANK_RESET;
			ram_bank   <= RAM_BANK_RESET;
			mbc1_mode  <= 1'b0;
			rtc_mode   <= 1'b0;
			ram_enable <= 1'b0;
		end else if (cart_wr) begin
			case (wr_region)
				// --------------------
				// 0000-1FFF ram gate
				region_ram_enable: begin
					ram_enable <= (cart_di[3:0] == RAM_ENABLE_KEY);
				end
				// 2000-3FFF rom bank, 0 maps to 1 except on MBC5
				region_rom_bank: begin
					if (mbc_kind != mbc_5 && cart_di[4:0] == 5'd0)
						rom_bank <= ROM_BANK_RESET;
					else
						rom_bank <= cart_di[6:0];
				end
				// 4000-5FFF ram bank, MBC3 also selects RTC here
				region_ram_bank: begin
					if (mbc_kind == mbc_3) begin
						if (cart_di[3]) begin
							rtc_mode <= 1'b1;
						end else begin
							rtc_mode <= 1'b0;
							ram_bank <= cart_di[1:0];
						end
					end else begin
						ram_bank <= cart_di[1:0];
					end
				end
				// 6000-7FFF banking mode, only MBC1 has it
				region_mode: begin
					if (mbc_kind == mbc_1)
						mbc1_mode <= cart_di[0];
				end
				// cart ram and I/O are not registers
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verif/gb_cart_asserts.sv
// --------------------
// assertions on the bank registers, bound into mbc_regs
// --------------------
`default_nettype none

module gb_cart_asserts
	import gb_cart_pkg::*;
(
	input logic      clk_sys,
	input logic      reset,
	input logic      dl_active,
	input mbc_kind_e mbc_kind,
	input rom_bank_t rom_bank,
	input ram_bank_t ram_bank,
	input logic      mbc1_mode,
	input logic      rtc_mode,
	input logic      ram_enable
);
	timeunit 1ns;
	timeprecision 1ps;

	// bank 0 in the upper window only exists on MBC5
	rom_bank_nonzero: assert property (@(posedge clk_sys) disable iff (reset || dl_active)
		(mbc_kind != mbc_5) |-> (rom_bank[4:0] != 5'd0))
		else $error("rom bank low bits are zero on a non MBC5 controller");

	// console held in reset while the rom downloads
	hold_values: assert property (@(posedge clk_sys) (reset || dl_active) |=>
		(rom_bank == 7'd1 && ram_bank == 2'd0 && !mbc1_mode && !rtc_mode && !ram_enable))
		else $error("bank registers left their reset values during reset or download");

	// only MBC3 has an RTC select
	rtc_only_mbc3: assert property (@(posedge clk_sys) disable iff (reset || dl_active)
		(mbc_kind != mbc_3) |=> $stable(rtc_mode))
		else $error("rtc mode changed on a controller other than MBC3");

endmodule

`default_nettype wire

// File: verif/gb_cart_tb.sv
// --------------------
// testbench for the cartridge bank controller
// downloads headers, drives console strobes on the falling edge and
// checks rom_addr and cart_do against a reference model
// --------------------
`default_nettype none

module gb_cart_tb
	import gb_bus_pkg::*, gb_cart_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	// well above the roughly 900 cycles that the tests below take
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int RESET_CYCLES   = 8;

	logic       clk_sys;
	logic       reset;
	logic       dl_active;
	logic       dl_wr;
	dl_addr_t   dl_addr;
	dl_data_t   dl_data;
	cart_addr_t cart_addr;
	logic       cart_rd;
	logic       cart_wr;
	cart_data_t cart_di;
	cart_data_t cart_do;
	rom_addr_t  rom_addr;

	// expectations handed from the stimulus to the compare process
	logic       rom_chk;
	rom_addr_t  rom_exp;
	cart_data_t rd_exp;
	logic       do_chk;
	cart_data_t do_exp;
	int         cycles = 0;
	logic [31:0] lfsr_state;

	// --------------------
	// reference model state
	mbc_kind_e  m_kind;
	rom_bank_t  m_rom_mask;
	ram_bank_t  m_ram_mask;
	rom_bank_t  m_rom_bank;
	ram_bank_t  m_ram_bank;
	logic       m_mode;
	logic       m_rtc;
	logic       m_ram_en;
	cart_data_t ref_mem [32768];

	gb_cart_top #(
		.CRAM_ADDR_W(15)
	) dut0 (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl_active(dl_active),
		.dl_wr    (dl_wr),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.cart_addr(cart_addr),
		.cart_rd  (cart_rd),
		.cart_wr  (cart_wr),
		.cart_di  (cart_di),
		.cart_do  (cart_do),
		.rom_addr (rom_addr)
	);

	bind mbc_regs gb_cart_asserts asrt0 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.mbc_kind  (mbc_kind),
		.rom_bank  (rom_bank),
		.ram_bank  (ram_bank),
		.mbc1_mode (mbc1_mode),
		.rtc_mode  (rtc_mode),
		.ram_enable(ram_enable)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
		end
		return r;
	endfunction

	function automatic cart_data_t rand_byte();
		logic [31:0] r;
		r = rand_bits(8);
		return r[7:0];
	endfunction

	// random address inside one 8K region, top selects it
	function automatic cart_addr_t region_addr(input logic [2:0] top);
		logic [31:0] r;
		r = rand_bits(13);
		return {top, r[12:0]};
	endfunction

	// --------------------
	// header decode tables
	function automatic mbc_kind_e ref_kind(input logic [7:0] t);
		if (t >= 8'd1 && t <= 8'd3)
			return mbc_1;
		if (t == 8'd5 || t == 8'd6)
			return mbc_2;
		if (t >= 8'd15 && t <= 8'd19)
			return mbc_3;
		if (t >= 8'd25 && t <= 8'd30)
			return mbc_5;
		return mbc_none;
	endfunction

	function automatic rom_bank_t ref_rom_mask(input logic [7:0] s);
		case (s)
			8'd1:    return 7'd3;
			8'd2:    return 7'd7;
			8'd3:    return 7'd15;
			8'd4:    return 7'd31;
			8'd5:    return 7'd63;
			8'd6:    return 7'd127;
			8'd82:   return 7'd71;
			8'd83:   return 7'd79;
			default: return 7'd95;
		endcase
	endfunction

	// expected rom byte address for the model's current registers
	function automatic rom_addr_t exp_rom_addr(input cart_addr_t addr);
		rom_bank_t bank;
		if (m_kind == mbc_1)
			bank = m_mode ? {2'b00, m_rom_bank[4:0]} : {m_ram_bank, m_rom_bank[4:0]};
		else
			bank = m_rom_bank;
		bank = bank & m_rom_mask;
		if (m_kind == mbc_none)
			return rom_addr_t'(addr[14:0]);
		if (addr < 16'h4000)
			return rom_addr_t'(addr);
		if (addr < 16'h8000)
			return rom_addr_t'(bank) * 22'h4000 + rom_addr_t'(addr[13:0]);
		return '0;
	endfunction

	function automatic cram_addr_t ram_index(input cart_addr_t addr);
		ram_bank_t bank;
		bank = 2'd0;
		if ((m_kind == mbc_1 && m_mode) || m_kind == mbc_3 || m_kind == mbc_5)
			bank = m_ram_bank;
		bank = bank & m_ram_mask;
		return {bank, addr[12:0]};
	endfunction

	function automatic cart_data_t exp_read(input cart_addr_t addr);
		cart_data_t stored;
		stored = ref_mem[ram_index(addr)];
		if (!m_ram_en)
			return 8'hFF;
		if (m_kind == mbc_2 && addr >= 16'hA000 && addr <= 16'hA1FF)
			return {4'hF, stored[3:0]};
		if (m_rtc)
			return 8'h00;
		return stored;
	endfunction

	// register and RAM write rules applied to the model
	function automatic void model_write(input cart_addr_t addr, input cart_data_t di);
		case (region_of(addr))
			region_ram_enable: m_ram_en = (di[3:0] == 4'hA);
			region_rom_bank: begin
				if (m_kind != mbc_5 && di[4:0] == 5'd0)
					m_rom_bank = 7'd1;
				else
					m_rom_bank = di[6:0];
			end
			region_ram_bank: begin
				if (m_kind == mbc_3 && di[3]) begin
					m_rtc = 1'b1;
				end else begin
					if (m_kind == mbc_3)
						m_rtc = 1'b0;
					m_ram_bank = di[1:0];
				end
			end
			region_mode: begin
				if (m_kind == mbc_1)
					m_mode = di[0];
			end
			region_cram: ref_mem[ram_index(addr)] = di;
			default: begin
			end
		endcase
	endfunction

	function automatic void model_regs_reset();
		m_rom_bank = 7'd1;
		m_ram_bank = 2'd0;
		m_mode     = 1'b0;
		m_rtc      = 1'b0;
		m_ram_en   = 1'b0;
	endfunction

	// --------------------
	// compare tasks
	task automatic check_rom_addr(input rom_addr_t exp, input rom_addr_t act);
		if (act !== exp) begin
			$display("[FAIL] %0d ns rom_addr expected %h actual %h", $time, exp, act);
			$display("*** TEST FAILED ***");
			$fatal(1, "rom_addr mismatch");
		end
	endtask

	task automatic check_cart_do(input cart_data_t exp, input cart_data_t act);
		if (act !== exp) begin
			$display("[FAIL] %0d ns cart_do expected %h actual %h", $time, exp, act);
			$display("*** TEST FAILED ***");
			$fatal(1, "cart_do mismatch");
		end
	endtask

	// --------------------
	// stimulus, one console cycle per call
	task automatic bus_cycle(input logic wr, input logic rd, input logic probe,
			input cart_addr_t addr, input cart_data_t di);
		@(negedge clk_sys);
		cart_wr   = wr;
		cart_rd   = rd;
		cart_addr = addr;
		cart_di   = di;
		rom_chk   = probe;
		rom_exp   = exp_rom_addr(addr);
		rd_exp    = exp_read(addr);
		if (wr)
			model_write(addr, di);
	endtask

	task automatic cart_write(input cart_addr_t addr, input cart_data_t di);
		bus_cycle(1'b1, 1'b0, 1'b0, addr, di);
	endtask

	task automatic ram_read(input cart_addr_t addr);
		bus_cycle(1'b0, 1'b1, 1'b0, addr, 8'h00);
	endtask

	task automatic rom_probe(input cart_addr_t addr);
		bus_cycle(1'b0, 1'b0, 1'b1, addr, 8'h00);
	endtask

	task automatic idle();
		bus_cycle(1'b0, 1'b0, 1'b0, 16'h0000, 8'h00);
	endtask

	// words 0140-014A with the header pair among random payload
	task automatic download(input logic [7:0] type_byte, input logic [7:0] rom_size,
			input logic [7:0] ram_size);
		logic [31:0] r;
		dl_addr_t a;
		int i;
		idle();
		dl_active = 1'b1;
		for (i = 0; i < 6; i++) begin
			r = rand_bits(16);
			a = 25'h140 + dl_addr_t'(2 * i);
			@(negedge clk_sys);
			dl_wr   = 1'b1;
			dl_addr = a;
			if (a == 25'h146)
				dl_data = {type_byte, r[7:0]};
			else if (a == 25'h148)
				dl_data = {ram_size, rom_size};
			else
				dl_data = r[15:0];
		end
		@(negedge clk_sys);
		dl_wr = 1'b0;
		@(negedge clk_sys);
		dl_active = 1'b0;
		m_kind     = ref_kind(type_byte);
		m_rom_mask = ref_rom_mask(rom_size);
		m_ram_mask = (ram_size == 8'd1 || ram_size == 8'd2) ? 2'd0 : 2'd3;
		model_regs_reset();
	endtask

	// random bank, ram bank and mode writes, probes in both rom halves
	task automatic bank_sweep(input int n);
		logic [31:0] r;
		int i;
		for (i = 0; i < n; i++) begin
			r = rand_bits(16);
			// a quarter carry zero in the low five bits
			cart_write(region_addr(3'b001), (r[1:0] == 2'b00) ? {r[15:13], 5'd0} : r[15:8]);
			cart_write(region_addr(3'b010), rand_byte());
			if (r[2])
				cart_write(region_addr(3'b011), rand_byte());
			rom_probe({2'b00, r[15:3], r[0]});
			rom_probe(region_addr(3'b010));
			rom_probe(region_addr(3'b011));
		end
	endtask

	// writes across ram banks then reads back, same or random bank
	task automatic ram_round(input int n, input logic same_bank);
		cart_addr_t addrs[$];
		logic [1:0] banks[$];
		logic [31:0] r;
		int i;
		for (i = 0; i < n; i++) begin
			r = rand_bits(2);
			banks.push_back(r[1:0]);
			cart_write(16'h4000, {6'd0, r[1:0]});
			addrs.push_back(region_addr(3'b101));
			cart_write(addrs[i], rand_byte());
		end
		for (i = 0; i < n; i++) begin
			r = rand_bits(2);
			cart_write(16'h4000, {6'd0, same_bank ? banks[i] : r[1:0]});
			ram_read(addrs[i]);
		end
	endtask

	// sampled at the rising edge, cart_do one edge after its read
	always @(posedge clk_sys) begin
		if (rom_chk)
			check_rom_addr(rom_exp, rom_addr);
		if (do_chk)
			check_cart_do(do_exp, cart_do);
		do_chk = cart_rd;
		do_exp = rd_exp;
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** TEST FAILED ***");
			$fatal(1, "timeout");
		end
	end

	initial begin
		cart_addr_t saved [6];
		logic [31:0] r;
		int i;
		reset      = 1'b1;
		dl_active  = 1'b0;
		dl_wr      = 1'b0;
		dl_addr    = '0;
		dl_data    = '0;
		cart_addr  = '0;
		cart_rd    = 1'b0;
		cart_wr    = 1'b0;
		cart_di    = '0;
		rom_chk    = 1'b0;
		rom_exp    = '0;
		rd_exp     = '0;
		do_chk     = 1'b0;
		do_exp     = '0;
		lfsr_state = 32'hb738_f980;
		m_kind     = ref_kind(8'h00);
		m_rom_mask = ref_rom_mask(8'h00);
		m_ram_mask = 2'd3;
		model_regs_reset();
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		check_cart_do(8'h00, cart_do);

		// no controller, plain 32K window
		download(8'h00, 8'h00, 8'h00);
		for (i = 0; i < 48; i++) begin
			r = rand_bits(15);
			rom_probe({1'b0, r[14:0]});
		end

		// MBC1 with a 128K and a 72 bank rom
		download(8'h01, 8'd2, 8'd3);
		bank_sweep(24);
		download(8'h03, 8'd82, 8'd3);
		bank_sweep(24);

		// MBC5 keeps bank 0, MBC3 masks to 16 banks
		download(8'd25, 8'd6, 8'd3);
		cart_write(16'h2000, 8'h00);
		rom_probe(16'h4000);
		rom_probe(16'h7FFF);
		bank_sweep(16);
		download(8'd17, 8'd3, 8'd3);
		bank_sweep(16);

		// cart RAM on MBC5, four banks, then closed, then one bank
		download(8'd27, 8'd6, 8'd3);
		cart_write(16'h0000, 8'h0A);
		ram_round(40, 1'b1);
		// same offset in each bank keeps the banks apart
		for (i = 0; i < 4; i++) begin
			cart_write(16'h4000, cart_data_t'(i));
			cart_write(16'hA000, rand_byte());
		end
		for (i = 0; i < 4; i++) begin
			cart_write(16'h4000, cart_data_t'(i));
			ram_read(16'hA000);
		end
		cart_write(16'h1000, 8'h00);
		for (i = 0; i < 8; i++)
			ram_read(region_addr(3'b101));
		download(8'd27, 8'd6, 8'd2);
		cart_write(16'h0000, 8'h0A);
		ram_round(16, 1'b0);

		// MBC2 nibble RAM
		download(8'd6, 8'd1, 8'd0);
		cart_write(16'h0000, 8'h0A);
		for (i = 0; i < 12; i++) begin
			r = rand_bits(9);
			cart_write({7'b1010000, r[8:0]}, rand_byte());
			ram_read({7'b1010000, r[8:0]});
		end

		// MBC3 RTC select blanks the RAM
		download(8'd16, 8'd2, 8'd3);
		cart_write(16'h0000, 8'h0A);
		cart_write(16'h4000, 8'h01);
		for (i = 0; i < 6; i++) begin
			saved[i] = region_addr(3'b101);
			cart_write(saved[i], rand_byte());
		end
		cart_write(16'h4000, 8'h08);
		for (i = 0; i < 6; i++)
			ram_read(saved[i]);
		cart_write(16'h4000, 8'h01);
		for (i = 0; i < 6; i++)
			ram_read(saved[i]);

		// a second download drops the bank back to 1
		download(8'h01, 8'd5, 8'd3);
		cart_write(16'h2000, 8'h05);
		rom_probe(16'h4000);
		download(8'h01, 8'd5, 8'd3);
		rom_probe(16'h4000);

		idle();
		idle();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
